// ==== rtl/mx_pkg.sv ====
package mx_pkg;

  // Block format
  localparam int MAN_WIDTH = 8;
  localparam int EXP_WIDTH = 8;

  // Default sizes for the top level
  localparam int DEF_IN_SIZE = 8;
  localparam int DEF_DEPTH   = 8;

  // One lane of a block, two's complement
  typedef logic signed [MAN_WIDTH-1:0] man_t;

  // Shared exponent, unsigned
  typedef logic [EXP_WIDTH-1:0] exp_t;

endpackage

// ==== rtl/mx_fifo.sv ====
`timescale 1ns/100ps
module mx_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 72
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] data_in,
  input  logic             data_in_valid,
  output logic             data_in_ready,
  output logic [WIDTH-1:0] data_out,
  output logic             data_out_valid,
  input  logic             data_out_ready
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH-1:0];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count == CW'(DEPTH));

  // A full FIFO still takes a word in the cycle one leaves
  assign data_in_ready  = !full || data_out_ready;
  assign data_out_valid = (count != '0);
  assign data_out       = mem[rd_ptr];

  assign push = data_in_valid && data_in_ready;
  assign pop  = data_out_valid && data_out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + CW'(1);
        2'b01:   count <= count - CW'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rtl/split2_with_data.sv ====
`timescale 1ns/100ps
module split2_with_data #(
  parameter int DEPTH   = mx_pkg::DEF_DEPTH,
  parameter int IN_SIZE = mx_pkg::DEF_IN_SIZE
) (
  input  logic clk,
  input  logic arst_n,
  input  logic [mx_pkg::MAN_WIDTH*IN_SIZE+mx_pkg::EXP_WIDTH-1:0] data_in,
  input  logic data_in_valid,
  output logic data_in_ready,
  output logic [mx_pkg::MAN_WIDTH*IN_SIZE+mx_pkg::EXP_WIDTH-1:0] fifo_data_out,
  output logic fifo_data_out_valid,
  input  logic fifo_data_out_ready,
  output logic [mx_pkg::MAN_WIDTH*IN_SIZE+mx_pkg::EXP_WIDTH-1:0] straight_data_out,
  output logic straight_data_out_valid,
  input  logic straight_data_out_ready
);
  import mx_pkg::*;

  localparam int FLAT_W = MAN_WIDTH * IN_SIZE + EXP_WIDTH;

  logic fifo_in_valid;
  logic fifo_in_ready;

  // Both branches take the block in the same cycle, or neither does
  assign data_in_ready           = fifo_in_ready && straight_data_out_ready;
  assign straight_data_out_valid = data_in_valid && fifo_in_ready;
  assign fifo_in_valid           = data_in_valid && straight_data_out_ready;
  assign straight_data_out       = data_in;

  mx_fifo #(
    .DEPTH(DEPTH),
    .WIDTH(FLAT_W)
  ) fifo_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .data_in       (data_in),
    .data_in_valid (fifo_in_valid),
    .data_in_ready (fifo_in_ready),
    .data_out      (fifo_data_out),
    .data_out_valid(fifo_data_out_valid),
    .data_out_ready(fifo_data_out_ready)
  );

endmodule

// ==== rtl/mxint_skid_buffer.sv ====
`timescale 1ns/100ps
module mxint_skid_buffer #(
  parameter int IN_SIZE = mx_pkg::DEF_IN_SIZE
) (
  input  logic         clk,
  input  logic         arst_n,
  input  mx_pkg::man_t mdata_in [IN_SIZE-1:0],
  input  mx_pkg::exp_t edata_in,
  input  logic         data_in_valid,
  output logic         data_in_ready,
  output mx_pkg::man_t mdata_out [IN_SIZE-1:0],
  output mx_pkg::exp_t edata_out,
  output logic         data_out_valid,
  input  logic         data_out_ready
);
  import mx_pkg::*;

  man_t skid_m [IN_SIZE-1:0];
  exp_t skid_e;
  logic skid_valid;
  logic in_xfer;
  logic main_load;

  // Ready comes straight from a flop
  assign data_in_ready = !skid_valid;
  assign in_xfer       = data_in_valid && data_in_ready;
  assign main_load     = !data_out_valid || data_out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_out_valid <= 1'b0;
      skid_valid     <= 1'b0;
    end else if (main_load) begin
      data_out_valid <= skid_valid || in_xfer;
      skid_valid     <= 1'b0;
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      if (skid_valid) begin
        mdata_out <= skid_m;
        edata_out <= skid_e;
      end else if (in_xfer) begin
        mdata_out <= mdata_in;
        edata_out <= edata_in;
      end
    end else if (in_xfer) begin
      // Park the block while main is stalled
      skid_m <= mdata_in;
      skid_e <= edata_in;
    end
  end

endmodule

// ==== rtl/unpacked_mx_split2_with_data.sv ====
`timescale 1ns/100ps
module unpacked_mx_split2_with_data #(
  parameter int DEPTH   = mx_pkg::DEF_DEPTH,
  parameter int IN_SIZE = mx_pkg::DEF_IN_SIZE
) (
  input  logic         clk,
  input  logic         arst_n,
  input  mx_pkg::man_t mdata_in [IN_SIZE-1:0],
  input  mx_pkg::exp_t edata_in,
  input  logic         data_in_valid,
  output logic         data_in_ready,
  output mx_pkg::man_t fifo_mdata_out [IN_SIZE-1:0],
  output mx_pkg::exp_t fifo_edata_out,
  output logic         fifo_data_out_valid,
  input  logic         fifo_data_out_ready,
  output mx_pkg::man_t straight_mdata_out [IN_SIZE-1:0],
  output mx_pkg::exp_t straight_edata_out,
  output logic         straight_data_out_valid,
  input  logic         straight_data_out_ready
);
  import mx_pkg::*;

  localparam int MW     = MAN_WIDTH * IN_SIZE;
  localparam int FLAT_W = MW + EXP_WIDTH;

  logic [FLAT_W-1:0] in_flat;
  logic [FLAT_W-1:0] fifo_flat;
  logic [FLAT_W-1:0] straight_flat;

  man_t fifo_mdata_unreg [IN_SIZE-1:0];
  exp_t fifo_edata_unreg;
  logic fifo_unreg_valid;
  logic fifo_unreg_ready;

  // Lane i at bits i*MAN_WIDTH, exponent on top
  for (genvar i = 0; i < IN_SIZE; i++) begin : g_lanes
    assign in_flat[i*MAN_WIDTH +: MAN_WIDTH] = mdata_in[i];
    assign fifo_mdata_unreg[i]   = fifo_flat[i*MAN_WIDTH +: MAN_WIDTH];
    assign straight_mdata_out[i] = straight_flat[i*MAN_WIDTH +: MAN_WIDTH];
  end
  assign in_flat[FLAT_W-1:MW] = edata_in;
  assign fifo_edata_unreg     = fifo_flat[FLAT_W-1:MW];
  assign straight_edata_out   = straight_flat[FLAT_W-1:MW];

  split2_with_data #(
    .DEPTH  (DEPTH),
    .IN_SIZE(IN_SIZE)
  ) split2_with_data_i (
    .clk                    (clk),
    .arst_n                 (arst_n),
    .data_in                (in_flat),
    .data_in_valid          (data_in_valid),
    .data_in_ready          (data_in_ready),
    .fifo_data_out          (fifo_flat),
    .fifo_data_out_valid    (fifo_unreg_valid),
    .fifo_data_out_ready    (fifo_unreg_ready),
    .straight_data_out      (straight_flat),
    .straight_data_out_valid(straight_data_out_valid),
    .straight_data_out_ready(straight_data_out_ready)
  );

  // Register slice after the FIFO
  mxint_skid_buffer #(
    .IN_SIZE(IN_SIZE)
  ) fifo_out_skid_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .mdata_in      (fifo_mdata_unreg),
    .edata_in      (fifo_edata_unreg),
    .data_in_valid (fifo_unreg_valid),
    .data_in_ready (fifo_unreg_ready),
    .mdata_out     (fifo_mdata_out),
    .edata_out     (fifo_edata_out),
    .data_out_valid(fifo_data_out_valid),
    .data_out_ready(fifo_data_out_ready)
  );

endmodule

// ==== rtl/mxint_relu.sv ====
`timescale 1ns/100ps
module mxint_relu #(
  parameter int IN_SIZE = mx_pkg::DEF_IN_SIZE
) (
  input  logic         clk,
  input  logic         arst_n,
  input  mx_pkg::man_t mdata_in [IN_SIZE-1:0],
  input  mx_pkg::exp_t edata_in,
  input  logic         data_in_valid,
  output logic         data_in_ready,
  output mx_pkg::man_t mdata_out [IN_SIZE-1:0],
  output mx_pkg::exp_t edata_out,
  output logic         data_out_valid,
  input  logic         data_out_ready
);
  import mx_pkg::*;

  assign data_in_ready = data_out_ready || !data_out_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_out_valid <= 1'b0;
    end else if (data_in_ready) begin
      data_out_valid <= data_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (data_in_valid && data_in_ready) begin
      for (int i = 0; i < IN_SIZE; i++) begin
        // Negative lanes go to zero
        mdata_out[i] <= mdata_in[i][MAN_WIDTH-1] ? man_t'(0) : mdata_in[i];
      end
      edata_out <= edata_in;
    end
  end

endmodule

// ==== rtl/mxint_residual_add.sv ====
`timescale 1ns/100ps
module mxint_residual_add #(
  parameter int IN_SIZE = mx_pkg::DEF_IN_SIZE
) (
  input  logic         clk,
  input  logic         arst_n,
  input  mx_pkg::man_t a_mdata [IN_SIZE-1:0],
  input  mx_pkg::exp_t a_edata,
  input  logic         a_valid,
  output logic         a_ready,
  input  mx_pkg::man_t b_mdata [IN_SIZE-1:0],
  input  mx_pkg::exp_t b_edata,
  input  logic         b_valid,
  output logic         b_ready,
  output mx_pkg::man_t mdata_out [IN_SIZE-1:0],
  output mx_pkg::exp_t edata_out,
  output logic         data_out_valid,
  input  logic         data_out_ready
);
  import mx_pkg::*;

  logic signed [MAN_WIDTH:0] sum [IN_SIZE-1:0];
  man_t norm_m [IN_SIZE-1:0];
  exp_t norm_e;
  logic ovf;
  logic can_accept;
  logic join_xfer;

  assign can_accept = !data_out_valid || data_out_ready;
  assign a_ready    = can_accept && b_valid;
  assign b_ready    = can_accept && a_valid;
  assign join_xfer  = a_valid && b_valid && can_accept;

  always_comb begin
    ovf = 1'b0;
    for (int i = 0; i < IN_SIZE; i++) begin
      sum[i] = {a_mdata[i][MAN_WIDTH-1], a_mdata[i]} + {b_mdata[i][MAN_WIDTH-1], b_mdata[i]};
      // Top two bits differ when the sum leaves the man_t range
      if (sum[i][MAN_WIDTH] != sum[i][MAN_WIDTH-1]) begin
        ovf = 1'b1;
      end
    end
  end

  // One overflowing lane shifts the whole block
  always_comb begin
    for (int i = 0; i < IN_SIZE; i++) begin
      norm_m[i] = ovf ? man_t'(sum[i][MAN_WIDTH:1]) : man_t'(sum[i][MAN_WIDTH-1:0]);
    end
    norm_e = ovf ? a_edata + exp_t'(1) : a_edata;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_out_valid <= 1'b0;
    end else if (can_accept) begin
      data_out_valid <= a_valid && b_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (join_xfer) begin
      mdata_out <= norm_m;
      edata_out <= norm_e;
    end
  end

endmodule

// ==== rtl/mx_residual_block.sv ====
`timescale 1ns/100ps
module mx_residual_block #(
  parameter int DEPTH   = mx_pkg::DEF_DEPTH,
  parameter int IN_SIZE = mx_pkg::DEF_IN_SIZE
) (
  input  logic         clk,
  input  logic         arst_n,
  input  mx_pkg::man_t in_mdata [IN_SIZE-1:0],
  input  mx_pkg::exp_t in_edata,
  input  logic         in_valid,
  output logic         in_ready,
  output mx_pkg::man_t out_mdata [IN_SIZE-1:0],
  output mx_pkg::exp_t out_edata,
  output logic         out_valid,
  input  logic         out_ready
);
  import mx_pkg::*;

  man_t fifo_mdata [IN_SIZE-1:0];
  exp_t fifo_edata;
  logic fifo_valid;
  logic fifo_ready;

  man_t straight_mdata [IN_SIZE-1:0];
  exp_t straight_edata;
  logic straight_valid;
  logic straight_ready;

  man_t relu_mdata [IN_SIZE-1:0];
  exp_t relu_edata;
  logic relu_valid;
  logic relu_ready;

  unpacked_mx_split2_with_data #(
    .DEPTH  (DEPTH),
    .IN_SIZE(IN_SIZE)
  ) split_i (
    .clk                    (clk),
    .arst_n                 (arst_n),
    .mdata_in               (in_mdata),
    .edata_in               (in_edata),
    .data_in_valid          (in_valid),
    .data_in_ready          (in_ready),
    .fifo_mdata_out         (fifo_mdata),
    .fifo_edata_out         (fifo_edata),
    .fifo_data_out_valid    (fifo_valid),
    .fifo_data_out_ready    (fifo_ready),
    .straight_mdata_out     (straight_mdata),
    .straight_edata_out     (straight_edata),
    .straight_data_out_valid(straight_valid),
    .straight_data_out_ready(straight_ready)
  );

  // Stands in for the layer on the straight branch
  mxint_relu #(
    .IN_SIZE(IN_SIZE)
  ) relu_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .mdata_in      (straight_mdata),
    .edata_in      (straight_edata),
    .data_in_valid (straight_valid),
    .data_in_ready (straight_ready),
    .mdata_out     (relu_mdata),
    .edata_out     (relu_edata),
    .data_out_valid(relu_valid),
    .data_out_ready(relu_ready)
  );

  mxint_residual_add #(
    .IN_SIZE(IN_SIZE)
  ) add_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .a_mdata       (relu_mdata),
    .a_edata       (relu_edata),
    .a_valid       (relu_valid),
    .a_ready       (relu_ready),
    .b_mdata       (fifo_mdata),
    .b_edata       (fifo_edata),
    .b_valid       (fifo_valid),
    .b_ready       (fifo_ready),
    .mdata_out     (out_mdata),
    .edata_out     (out_edata),
    .data_out_valid(out_valid),
    .data_out_ready(out_ready)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps
module tb_clock_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release just after an edge, away from the flops
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
  end

endmodule

// ==== verification/mx_residual_block_tb.sv ====
`timescale 1ns/100ps
module mx_residual_block_tb;
  import mx_pkg::*;

  localparam int IN_SIZE = DEF_IN_SIZE;
  localparam int DEPTH   = DEF_DEPTH;
  localparam int TIMEOUT = 1000;
  localparam int MAN_MAX = 2 ** (MAN_WIDTH - 1) - 1;
  localparam int MAN_MIN = -(2 ** (MAN_WIDTH - 1));
  localparam int N_BP    = 40;

  typedef logic [IN_SIZE-1:0][MAN_WIDTH-1:0] lanes_t;

  logic   clk;
  logic   arst_n;
  man_t   in_mdata [IN_SIZE-1:0];
  exp_t   in_edata;
  logic   in_valid;
  logic   in_ready;
  man_t   out_mdata [IN_SIZE-1:0];
  exp_t   out_edata;
  logic   out_valid;
  logic   out_ready;

  lanes_t exp_m_q [$];
  exp_t   exp_e_q [$];
  string  test_name = "startup";
  int     seed = 32'h9a2ef309;
  int     errors = 0;
  int     rx_count = 0;
  int     tests_run = 0;
  int     tests_failed = 0;

  tb_clock_gen clock_gen_i (
    .clk   (clk),
    .arst_n(arst_n)
  );

  mx_residual_block #(
    .DEPTH  (DEPTH),
    .IN_SIZE(IN_SIZE)
  ) mx_residual_block_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_mdata (in_mdata),
    .in_edata (in_edata),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_mdata(out_mdata),
    .out_edata(out_edata),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  // x + relu(x) per lane, then one shared shift if any lane leaves the range
  function automatic void model_block(input lanes_t x, input exp_t e,
                                      output lanes_t y, output exp_t ye);
    int s [IN_SIZE];
    int v;
    bit ovf;
    ovf = 1'b0;
    for (int i = 0; i < IN_SIZE; i++) begin
      v    = int'($signed(x[i]));
      s[i] = v + ((v > 0) ? v : 0);
      if (s[i] > MAN_MAX || s[i] < MAN_MIN) begin
        ovf = 1'b1;
      end
    end
    for (int i = 0; i < IN_SIZE; i++) begin
      y[i] = ovf ? man_t'(s[i] >>> 1) : man_t'(s[i]);
    end
    ye = ovf ? exp_t'(e + 1) : e;
  endfunction

  task automatic random_block(output lanes_t x, output exp_t e);
    for (int i = 0; i < IN_SIZE; i++) begin
      x[i] = man_t'($random(seed));
    end
    // Keep well clear of exponent wrap
    e = exp_t'($random(seed) & 32'h7f);
  endtask

  task automatic check_output();
    lanes_t got_m;
    lanes_t want_m;
    exp_t   want_e;
    for (int i = 0; i < IN_SIZE; i++) begin
      got_m[i] = out_mdata[i];
    end
    rx_count++;
    if (exp_m_q.size() == 0) begin
      $display("%s: an output block arrived with no block outstanding", test_name);
      errors++;
    end else begin
      want_m = exp_m_q.pop_front();
      want_e = exp_e_q.pop_front();
      assert (got_m == want_m && out_edata == want_e) else begin
        $display("[ERROR] %s: expected m=%h e=%h, actual m=%h e=%h",
                 test_name, want_m, want_e, got_m, out_edata);
        errors++;
      end
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n && out_valid && out_ready) begin
      check_output();
    end
  end

  task automatic send_block(input lanes_t x, input exp_t e);
    lanes_t y;
    exp_t   ye;
    int     waited;
    model_block(x, e, y, ye);
    exp_m_q.push_back(y);
    exp_e_q.push_back(ye);
    for (int i = 0; i < IN_SIZE; i++) begin
      in_mdata[i] = man_t'(x[i]);
    end
    in_edata = e;
    in_valid = 1'b1;
    waited   = 0;
    @(negedge clk);
    while (!in_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      $display("%s: timed out waiting for in_ready", test_name);
      errors++;
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_m_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_m_q.size() != 0) begin
      $display("%s: timed out with %0d blocks missing at the output",
               test_name, exp_m_q.size());
      errors++;
      exp_m_q.delete();
      exp_e_q.delete();
    end
  endtask

  task automatic report_test(input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, errors - start_errors);
    end
  endtask

  task automatic check_reset_state();
    int start;
    int waited;
    test_name = "reset_state";
    start     = errors;
    waited    = 0;
    while (arst_n !== 1'b1 && waited < TIMEOUT) begin
      @(negedge clk);
      assert (out_valid == 1'b0) else begin
        $display("[ERROR] %s: out_valid expected 0, actual %b", test_name, out_valid);
        errors++;
      end
      waited++;
    end
    if (arst_n !== 1'b1) begin
      $display("%s: timed out waiting for reset release", test_name);
      errors++;
    end
    waited = 0;
    @(negedge clk);
    while (!in_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      $display("%s: in_ready did not rise after reset", test_name);
      errors++;
    end
    assert (out_valid == 1'b0) else begin
      $display("[ERROR] %s: out_valid expected 0, actual %b", test_name, out_valid);
      errors++;
    end
    @(posedge clk);
    #1;
    report_test(start);
  endtask

  task automatic send_single_block();
    int     vals [IN_SIZE] = '{5, -3, 12, -1, 0, 30, -20, 7};
    lanes_t x;
    int     start;
    test_name = "single_block";
    start     = errors;
    for (int i = 0; i < IN_SIZE; i++) begin
      x[i] = man_t'(vals[i]);
    end
    send_block(x, exp_t'(10));
    wait_drain();
    report_test(start);
  endtask

  // 100 doubles past the mantissa range
  task automatic send_overflow_block();
    int     vals [IN_SIZE] = '{100, 3, -5, 1, -128, 63, 0, -1};
    lanes_t x;
    int     start;
    test_name = "overflow";
    start     = errors;
    for (int i = 0; i < IN_SIZE; i++) begin
      x[i] = man_t'(vals[i]);
    end
    send_block(x, exp_t'(20));
    wait_drain();
    report_test(start);
  endtask

  task automatic stream_random_blocks();
    lanes_t x;
    exp_t   e;
    int     start;
    test_name = "random_stream";
    start     = errors;
    out_ready = 1'b1;
    for (int n = 0; n < 50; n++) begin
      random_block(x, e);
      send_block(x, e);
    end
    wait_drain();
    report_test(start);
  endtask

  task automatic stream_with_back_pressure();
    lanes_t blocks [N_BP];
    exp_t   exps [N_BP];
    int     start;
    int     rx_start;
    int     waited;
    bit     send_done;
    bit     saw_low;
    test_name = "back_pressure";
    start     = errors;
    rx_start  = rx_count;
    waited    = 0;
    send_done = 1'b0;
    saw_low   = 1'b0;
    for (int n = 0; n < N_BP; n++) begin
      random_block(blocks[n], exps[n]);
    end
    out_ready = 1'b0;
    fork
      begin
        for (int n = 0; n < N_BP; n++) begin
          send_block(blocks[n], exps[n]);
        end
        send_done = 1'b1;
      end
      begin
        for (int c = 0; c < DEPTH + 8; c++) begin
          @(negedge clk);
          if (!in_ready) begin
            saw_low = 1'b1;
          end
        end
        assert (saw_low) else begin
          $display("%s: in_ready never dropped while out_ready was held low", test_name);
          errors++;
        end
        while (!send_done && waited < TIMEOUT) begin
          @(posedge clk);
          #1;
          out_ready = ($random(seed) & 3) != 0;
          waited++;
        end
      end
    join
    out_ready = 1'b1;
    wait_drain();
    assert (rx_count - rx_start == N_BP) else begin
      $display("[ERROR] %s: block count expected %0d, actual %0d",
               test_name, N_BP, rx_count - rx_start);
      errors++;
    end
    report_test(start);
  endtask

  initial begin
    in_valid  = 1'b0;
    in_edata  = '0;
    out_ready = 1'b1;
    for (int i = 0; i < IN_SIZE; i++) begin
      in_mdata[i] = '0;
    end
    check_reset_state();
    send_single_block();
    send_overflow_block();
    stream_random_blocks();
    stream_with_back_pressure();
    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rtl/mx_pkg.sv
rtl/mx_fifo.sv
rtl/split2_with_data.sv
rtl/mxint_skid_buffer.sv
rtl/unpacked_mx_split2_with_data.sv
rtl/mxint_relu.sv
rtl/mxint_residual_add.sv
rtl/mx_residual_block.sv
verification/tb_clock_gen.sv
verification/mx_residual_block_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mx_residual_block_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
